//--- hw/executePkg.sv
package executePkg;

	localparam int dataWidth = 32; // register and data width
	localparam int regNumWidth = 5;
	localparam int numRegs = 32;

	typedef logic [dataWidth-1:0] dataT; // register values, immediates, pcs
	typedef logic [regNumWidth-1:0] regNumT;
	typedef logic [2:0] func3T;
	typedef logic [6:0] func7T;
	typedef logic [6:0] opcodeT;

	// RV32I major opcodes handled by this stage
	localparam opcodeT opcodeR = 7'b0110011;
	localparam opcodeT opcodeImm = 7'b0010011;
	localparam opcodeT opcodeLoad = 7'b0000011;
	localparam opcodeT opcodeStore = 7'b0100011;
	localparam opcodeT opcodeBranch = 7'b1100011;
	localparam opcodeT opcodeJal = 7'b1101111;
	localparam opcodeT opcodeJalr = 7'b1100111;
	localparam opcodeT opcodeLui = 7'b0110111;
	localparam opcodeT opcodeAuipc = 7'b0010111;

	typedef enum logic [3:0]
	{
		aluAdd,
		aluSub,
		aluSll,
		aluSrl,
		aluSra,
		aluSlt, // signed less-than
		aluSltu,
		aluXor,
		aluOr,
		aluAnd,
		aluEq,
		aluNe,
		aluGe, // signed greater-or-equal
		aluGeu
	} aluOpT;

	typedef enum logic [2:0]
	{
		kindIdle,
		kindRegWrite,
		kindMemReadRegWrite,
		kindMemWrite,
		kindBranch,
		kindJump,
		kindLuiRegWrite
	} stageKindT;

	typedef struct packed
	{
		dataT pc;
		dataT imm;
		func3T func3;
		regNumT rs1;
		regNumT rs2;
		regNumT rd;
	} decodedInstrT;

	// contents of the execute/writeback pipeline register
	typedef struct packed
	{
		stageKindT kind;
		dataT aluOut; // result, address or compare flag
		dataT storeData; // resolved rs2
		dataT pc;
		dataT imm;
		func3T func3;
		regNumT rd;
	} execResultT;

endpackage

//--- hw/aluUnit.sv
`timescale 1ns/1ps

module aluUnit
(
	input executePkg::aluOpT aluOp,
	input executePkg::dataT x,
	input executePkg::dataT y,
	output executePkg::dataT result
);

	import executePkg::*;

	logic [4:0] shamt;
	logic lessSigned;
	logic lessUnsigned;

	assign shamt = y[4:0]; // only low five bits shift
	assign lessSigned = $signed(x) < $signed(y);
	assign lessUnsigned = x < y;

	always_comb
	begin
		case (aluOp)
			aluAdd:
				result = x + y;
			aluSub:
				result = x - y;
			aluSll:
				result = x << shamt;
			aluSrl:
				result = x >> shamt;
			aluSra:
				result = dataT'($signed(x) >>> shamt);
			aluSlt:
				result = dataT'(lessSigned);
			aluSltu:
				result = dataT'(lessUnsigned);
			aluXor:
				result = x ^ y;
			aluOr:
				result = x | y;
			aluAnd:
				result = x & y;
			aluEq:
				result = dataT'(x == y); // compares give 1 or 0
			aluNe:
				result = dataT'(x != y);
			aluGe:
				result = dataT'(!lessSigned);
			aluGeu:
				result = dataT'(!lessUnsigned);
			default:
				result = '0;
		endcase
	end

endmodule

//--- hw/opDecoder.sv
`timescale 1ns/1ps

module opDecoder
(
	input executePkg::opcodeT opcode,
	input executePkg::func3T func3,
	input executePkg::func7T func7,
	input executePkg::dataT imm,
	input logic flush,
	output executePkg::aluOpT aluOp,
	output logic useImm,
	output logic usePc,
	output executePkg::stageKindT kind
);

	import executePkg::*;

	logic altBit;

	// R-type carries the alternate-op bit in func7, immediate shifts in imm
	assign altBit = (opcode == opcodeR) ? func7[5] : imm[10];

	always_comb
	begin
		aluOp = aluAdd; // bubble defaults
		useImm = 1'b0;
		usePc = 1'b0;
		kind = kindIdle;
		if (!flush)
		begin
			case (opcode)
				opcodeR, opcodeImm:
				begin
					useImm = (opcode == opcodeImm);
					kind = kindRegWrite;
					case (func3)
						3'd0: aluOp = (opcode == opcodeR && func7[5]) ? aluSub : aluAdd;
						3'd1: aluOp = aluSll;
						3'd2: aluOp = aluSlt;
						3'd3: aluOp = aluSltu;
						3'd4: aluOp = aluXor;
						3'd5: aluOp = altBit ? aluSra : aluSrl;
						3'd6: aluOp = aluOr;
						default: aluOp = aluAnd;
					endcase
				end
				opcodeLoad:
				begin
					useImm = 1'b1; // address is rs1 + imm
					kind = kindMemReadRegWrite;
				end
				opcodeStore:
				begin
					useImm = 1'b1;
					kind = kindMemWrite;
				end
				opcodeBranch:
				begin
					kind = kindBranch;
					case (func3)
						3'd0: aluOp = aluEq; // beq
						3'd1: aluOp = aluNe; // bne
						3'd4: aluOp = aluSlt; // blt
						3'd5: aluOp = aluGe; // bge
						3'd6: aluOp = aluSltu; // bltu
						3'd7: aluOp = aluGeu; // bgeu
						default: kind = kindIdle; // reserved encodings
					endcase
				end
				opcodeJal:
				begin
					usePc = 1'b1; // target pc + imm
					useImm = 1'b1;
					kind = kindJump;
				end
				opcodeJalr:
				begin
					useImm = 1'b1; // target rs1 + imm
					kind = kindJump;
				end
				opcodeLui:
				begin
					useImm = 1'b1;
					kind = kindLuiRegWrite;
				end
				opcodeAuipc:
				begin
					usePc = 1'b1;
					useImm = 1'b1;
					kind = kindRegWrite;
				end
				default:
					kind = kindIdle;
			endcase
		end
	end

endmodule

//--- hw/forwardUnit.sv
`timescale 1ns/1ps

module forwardUnit
(
	input executePkg::regNumT rs1,
	input executePkg::regNumT rs2,
	input executePkg::dataT readData0,
	input executePkg::dataT readData1,
	input logic wbEnable,
	input executePkg::regNumT wbNum,
	input executePkg::dataT wbData,
	output executePkg::dataT operandA,
	output executePkg::dataT operandB
);

	import executePkg::*;

	logic hitA;
	logic hitB;

	// the instruction in writeback has not reached the register file yet
	assign hitA = wbEnable && (wbNum == rs1) && (rs1 != '0);
	assign hitB = wbEnable && (wbNum == rs2) && (rs2 != '0);

	assign operandA = hitA ? wbData : readData0;
	assign operandB = hitB ? wbData : readData1;

	// x0 must come out as zero whatever the writeback side is doing
	always_comb
	begin
		if (rs1 == '0)
			assert final (operandA == '0)
				else $error("operand A for x0 is nonzero");
		if (rs2 == '0)
			assert final (operandB == '0)
				else $error("operand B for x0 is nonzero");
	end

endmodule

//--- hw/regFile.sv
`timescale 1ns/1ps

module regFile
(
	input logic clk,
	input logic reset,
	input logic writeEnable,
	input executePkg::regNumT writeNum,
	input executePkg::dataT writeData,
	input executePkg::regNumT readNum0,
	input executePkg::regNumT readNum1,
	output executePkg::dataT readData0,
	output executePkg::dataT readData1
);

	import executePkg::*;

	dataT regs [numRegs];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < numRegs; i++)
				regs[i] <= '0;
		end
		else if (writeEnable && writeNum != '0)
			regs[writeNum] <= writeData; // x0 never written
	end

	// asynchronous reads, x0 hardwired
	assign readData0 = (readNum0 == '0) ? '0 : regs[readNum0];
	assign readData1 = (readNum1 == '0) ? '0 : regs[readNum1];

endmodule

//--- hw/writebackController.sv
`timescale 1ns/1ps

module writebackController
(
	input executePkg::execResultT result,
	input executePkg::dataT memReadData,
	output logic pcWriteEnable,
	output executePkg::dataT pcWriteData,
	output logic memReadEnable,
	output logic memWriteEnable,
	output executePkg::dataT memAddr,
	output executePkg::dataT memWriteData,
	output executePkg::func3T memFunc3,
	output logic regWriteEnable,
	output executePkg::regNumT regWriteNum,
	output executePkg::dataT regWriteData
);

	import executePkg::*;

	logic [7:0] loadByte;
	logic [15:0] loadHalf;
	logic [4:0] laneShift;
	dataT loadValue;
	logic writesReg;

	assign memAddr = result.aluOut;
	assign memFunc3 = result.func3;
	assign memReadEnable = (result.kind == kindMemReadRegWrite);
	assign memWriteEnable = (result.kind == kindMemWrite);
	assign laneShift = {memAddr[1:0], 3'b000}; // byte offset in bits

	// store data moved into the lanes picked by the low address bits
	always_comb
	begin
		case (result.func3[1:0])
			2'd0: memWriteData = dataT'(result.storeData[7:0]) << laneShift;
			2'd1: memWriteData = dataT'(result.storeData[15:0]) << {memAddr[1], 4'b0000};
			default: memWriteData = result.storeData;
		endcase
	end

	assign loadByte = memReadData[laneShift +: 8];
	assign loadHalf = memAddr[1] ? memReadData[31:16] : memReadData[15:0];

	always_comb
	begin
		case (result.func3)
			3'd0: loadValue = {{24{loadByte[7]}}, loadByte}; // lb
			3'd1: loadValue = {{16{loadHalf[15]}}, loadHalf}; // lh
			3'd4: loadValue = {24'b0, loadByte}; // lbu
			3'd5: loadValue = {16'b0, loadHalf}; // lhu
			default: loadValue = memReadData;
		endcase
	end

	// jump targets always land on an even address
	assign pcWriteEnable = (result.kind == kindJump) ||
		(result.kind == kindBranch && result.aluOut[0]);
	assign pcWriteData = (result.kind == kindJump) ? {result.aluOut[31:1], 1'b0} :
		result.pc + result.imm;

	assign writesReg = (result.kind == kindRegWrite) || (result.kind == kindMemReadRegWrite) ||
		(result.kind == kindJump) || (result.kind == kindLuiRegWrite);
	assign regWriteEnable = writesReg && (result.rd != '0);
	assign regWriteNum = result.rd;

	always_comb
	begin
		case (result.kind)
			kindMemReadRegWrite: regWriteData = loadValue;
			kindJump: regWriteData = result.pc + 32'd4; // link address
			kindLuiRegWrite: regWriteData = result.imm;
			default: regWriteData = result.aluOut;
		endcase
	end

	always_comb
	begin
		assert final (!(memReadEnable === 1'b1 && memWriteEnable === 1'b1))
			else $error("memory read and write strobes both high");
	end

endmodule

//--- hw/executeStage.sv
`timescale 1ns/1ps

module executeStage
(
	input logic clk,
	input logic reset,
	input logic flush,
	input executePkg::dataT pc,
	input executePkg::dataT imm,
	input executePkg::func3T func3,
	input executePkg::func7T func7,
	input executePkg::opcodeT opcode,
	input executePkg::regNumT regNum0,
	input executePkg::regNumT regNum1,
	input executePkg::regNumT regWriteNumIn,
	input executePkg::dataT memReadData,
	output logic pcWriteEnable,
	output executePkg::dataT pcWriteData,
	output logic memReadEnable,
	output logic memWriteEnable,
	output executePkg::dataT memAddr,
	output executePkg::dataT memWriteData,
	output executePkg::func3T memFunc3,
	output logic regWriteEnable,
	output executePkg::regNumT regWriteNum,
	output executePkg::dataT regWriteData
);

	import executePkg::*;

	decodedInstrT instr;
	aluOpT aluOp;
	logic useImm;
	logic usePc;
	stageKindT kind;
	dataT readData0;
	dataT readData1;
	dataT operandA;
	dataT operandB;
	dataT aluX;
	dataT aluY;
	dataT aluOut;
	execResultT exNext;
	execResultT exResult;

	assign instr = '{pc: pc, imm: imm, func3: func3, rs1: regNum0, rs2: regNum1,
		rd: regWriteNumIn};

	opDecoder decoder
	(
		.opcode(opcode),
		.func3(func3),
		.func7(func7),
		.imm(imm),
		.flush(flush),
		.aluOp(aluOp),
		.useImm(useImm),
		.usePc(usePc),
		.kind(kind)
	);

	regFile regs
	(
		.clk(clk),
		.reset(reset),
		.writeEnable(regWriteEnable),
		.writeNum(regWriteNum),
		.writeData(regWriteData),
		.readNum0(instr.rs1),
		.readNum1(instr.rs2),
		.readData0(readData0),
		.readData1(readData1)
	);

	forwardUnit forward
	(
		.rs1(instr.rs1),
		.rs2(instr.rs2),
		.readData0(readData0),
		.readData1(readData1),
		.wbEnable(regWriteEnable),
		.wbNum(regWriteNum),
		.wbData(regWriteData),
		.operandA(operandA),
		.operandB(operandB)
	);

	assign aluX = usePc ? instr.pc : operandA; // jal and auipc add to pc
	assign aluY = useImm ? instr.imm : operandB;

	aluUnit alu
	(
		.aluOp(aluOp),
		.x(aluX),
		.y(aluY),
		.result(aluOut)
	);

	assign exNext = '{kind: kind, aluOut: aluOut, storeData: operandB, pc: instr.pc,
		imm: instr.imm, func3: instr.func3, rd: instr.rd};

	// loaded every cycle, a bubble simply carries kind idle
	always_ff @(posedge clk)
	begin
		exResult <= exNext;
		if (reset)
			exResult.kind <= kindIdle;
	end

	writebackController writeback
	(
		.result(exResult),
		.memReadData(memReadData),
		.pcWriteEnable(pcWriteEnable),
		.pcWriteData(pcWriteData),
		.memReadEnable(memReadEnable),
		.memWriteEnable(memWriteEnable),
		.memAddr(memAddr),
		.memWriteData(memWriteData),
		.memFunc3(memFunc3),
		.regWriteEnable(regWriteEnable),
		.regWriteNum(regWriteNum),
		.regWriteData(regWriteData)
	);

endmodule

//--- verif/executeStageTb.sv
`timescale 1ns/1ps

module executeStageTb;

	import executePkg::*;

	typedef struct packed
	{
		opcodeT opcode;
		func3T func3;
		func7T func7;
		regNumT rs1;
		regNumT rs2;
		regNumT rd;
		dataT imm;
		dataT pc;
		dataT memData; // returned by memory one cycle after issue
		logic flush;
	} rowT;

	typedef struct packed
	{
		logic pcWe;
		dataT pcData;
		logic memRe;
		logic memWe;
		dataT addr;
		dataT wdata;
		logic regWe;
		dataT regData;
	} expectT;

	logic clk;
	logic reset;
	logic flush;
	dataT pc;
	dataT imm;
	func3T func3;
	func7T func7;
	opcodeT opcode;
	regNumT regNum0;
	regNumT regNum1;
	regNumT regWriteNumIn;
	dataT memReadData;
	logic pcWriteEnable;
	dataT pcWriteData;
	logic memReadEnable;
	logic memWriteEnable;
	dataT memAddr;
	dataT memWriteData;
	func3T memFunc3;
	logic regWriteEnable;
	regNumT regWriteNum;
	dataT regWriteData;

	rowT rows [$];
	dataT refRegs [numRegs]; // architectural register state
	logic [31:0] rngState;
	int checks;
	int errors;

	executeStage DUT (.*);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	function automatic logic [31:0] xorshift(logic [31:0] s);
		logic [31:0] v;
		v = s;
		v ^= v << 13;
		v ^= v >> 17;
		v ^= v << 5;
		return v;
	endfunction

	// RV32I integer ops, alt picks sub or arithmetic shift
	function automatic dataT arith(func3T f3, logic alt, dataT a, dataT b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return dataT'($signed(a) < $signed(b));
			3'd3: return dataT'(a < b);
			3'd4: return a ^ b;
			3'd5: return alt ? dataT'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branchTaken(func3T f3, dataT a, dataT b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			default: return a >= b;
		endcase
	endfunction

	function automatic dataT loadExtend(func3T f3, dataT addr, dataT md);
		logic [7:0] b;
		logic [15:0] h;
		b = md[8*addr[1:0] +: 8];
		h = md[16*addr[1] +: 16];
		case (f3)
			3'd0: return {{24{b[7]}}, b};
			3'd1: return {{16{h[15]}}, h};
			3'd4: return {24'b0, b};
			3'd5: return {16'b0, h};
			default: return md;
		endcase
	endfunction

	function automatic dataT storeLanes(func3T f3, dataT addr, dataT v);
		dataT w;
		w = '0; // unused lanes stay zero
		case (f3)
			3'd0: w[8*addr[1:0] +: 8] = v[7:0];
			3'd1: w[16*addr[1] +: 16] = v[15:0];
			default: w = v;
		endcase
		return w;
	endfunction

	function automatic expectT predict(rowT r);
		expectT e;
		dataT a;
		dataT b;
		e = '0;
		a = (r.rs1 == '0) ? '0 : refRegs[r.rs1];
		b = (r.rs2 == '0) ? '0 : refRegs[r.rs2];
		if (!r.flush)
		begin
			e.regWe = 1'b1;
			case (r.opcode)
				opcodeR: e.regData = arith(r.func3, r.func7[5], a, b);
				opcodeImm: e.regData = arith(r.func3, r.func3 == 3'd5 && r.imm[10], a, r.imm);
				opcodeLoad:
				begin
					e.memRe = 1'b1;
					e.addr = a + r.imm;
					e.regData = loadExtend(r.func3, e.addr, r.memData);
				end
				opcodeStore:
				begin
					e.regWe = 1'b0;
					e.memWe = 1'b1;
					e.addr = a + r.imm;
					e.wdata = storeLanes(r.func3, e.addr, b);
				end
				opcodeBranch:
				begin
					e.regWe = 1'b0;
					e.pcWe = branchTaken(r.func3, a, b);
					e.pcData = r.pc + r.imm;
				end
				opcodeJal, opcodeJalr:
				begin
					e.pcWe = 1'b1;
					e.pcData = (r.opcode == opcodeJal) ? r.pc + r.imm : (a + r.imm) & ~32'h1;
					e.regData = r.pc + 32'd4; // link
				end
				opcodeLui: e.regData = r.imm;
				opcodeAuipc: e.regData = r.pc + r.imm;
				default: e.regWe = 1'b0;
			endcase
		end
		if (r.rd == '0)
			e.regWe = 1'b0;
		return e;
	endfunction

	function automatic logic strobesLow();
		return pcWriteEnable === 1'b0 && memReadEnable === 1'b0 &&
			memWriteEnable === 1'b0 && regWriteEnable === 1'b0;
	endfunction

	task automatic addRow(opcodeT op, func3T f3, func7T f7, regNumT s1, regNumT s2, regNumT d,
		dataT im, dataT md, logic fl);
		rows.push_back('{opcode: op, func3: f3, func7: f7, rs1: s1, rs2: s2, rd: d, imm: im,
			pc: 32'h100 + 4 * rows.size(), memData: md, flush: fl});
	endtask

	task automatic checkValue(string what, int idx, dataT got, dataT want);
		checks++;
		if (got !== want)
		begin
			errors++;
			$display("ERROR time %0t: row %0d %s is %h, expected %h", $time, idx, what, got, want);
		end
	endtask

	task automatic checkRow(int idx, rowT r, expectT e);
		checkValue("pcWriteEnable", idx, pcWriteEnable, e.pcWe);
		checkValue("memReadEnable", idx, memReadEnable, e.memRe);
		checkValue("memWriteEnable", idx, memWriteEnable, e.memWe);
		checkValue("regWriteEnable", idx, regWriteEnable, e.regWe);
		if (e.pcWe)
			checkValue("pcWriteData", idx, pcWriteData, e.pcData);
		if (e.memRe || e.memWe)
		begin
			checkValue("memAddr", idx, memAddr, e.addr);
			checkValue("memFunc3", idx, memFunc3, r.func3);
		end
		if (e.memWe)
			checkValue("memWriteData", idx, memWriteData, e.wdata);
		if (e.regWe)
		begin
			checkValue("regWriteNum", idx, regWriteNum, r.rd);
			checkValue("regWriteData", idx, regWriteData, e.regData);
		end
	endtask

	task automatic buildTable();
		addRow(opcodeImm, 0, 0, 0, 0, 1, 5, 0, 0); // x1 = 5
		addRow(opcodeImm, 0, 0, 1, 0, 2, -3, 0, 0); // x1 forwarded
		addRow(opcodeR, 0, 0, 1, 2, 3, 0, 0, 0); // x1 from regfile, x2 forwarded
		addRow(opcodeR, 0, 7'h20, 1, 3, 4, 0, 0, 0); // sub
		addRow(opcodeLui, 0, 0, 0, 0, 5, 32'h8000_0000, 0, 0);
		addRow(opcodeImm, 5, 0, 5, 0, 6, 32'h404, 0, 0); // srai via imm bit 10
		addRow(opcodeImm, 5, 0, 5, 0, 7, 4, 0, 0); // srli
		addRow(opcodeR, 1, 0, 1, 2, 8, 0, 0, 0);
		addRow(opcodeR, 2, 0, 4, 1, 9, 0, 0, 0);
		addRow(opcodeR, 3, 0, 4, 1, 10, 0, 0, 0);
		addRow(opcodeImm, 4, 0, 4, 0, 11, 32'hff, 0, 0);
		addRow(opcodeR, 6, 0, 1, 3, 12, 0, 0, 0);
		addRow(opcodeImm, 7, 0, 3, 0, 13, 6, 0, 0);
		addRow(opcodeImm, 0, 0, 1, 0, 0, 9, 0, 0); // rd x0, no write
		addRow(opcodeR, 5, 7'h20, 4, 2, 14, 0, 0, 0); // sra
		addRow(opcodeAuipc, 0, 0, 0, 0, 15, 32'h1000, 0, 0);
		addRow(opcodeStore, 2, 0, 1, 4, 31, 3, 0, 0); // sw at 8
		addRow(opcodeStore, 0, 0, 1, 1, 0, 2, 0, 0); // sb into lane 3
		addRow(opcodeStore, 1, 0, 1, 4, 0, 1, 0, 0); // sh upper half
		addRow(opcodeLoad, 0, 0, 1, 0, 16, 0, 32'h1234_80ab, 0); // lb lane 1
		addRow(opcodeLoad, 4, 0, 1, 0, 17, 0, 32'h1234_80ab, 0);
		addRow(opcodeLoad, 1, 0, 1, 0, 18, 1, 32'h9abc_0000, 0);
		addRow(opcodeLoad, 5, 0, 1, 0, 19, 1, 32'h9abc_1111, 0);
		addRow(opcodeLoad, 2, 0, 1, 0, 20, 3, 32'hcafe_f00d, 0);
		addRow(opcodeBranch, 0, 0, 1, 1, 0, 16, 0, 0); // beq taken
		addRow(opcodeImm, 0, 0, 1, 0, 22, 1, 0, 1); // flushed
		addRow(opcodeBranch, 1, 0, 1, 1, 31, 16, 0, 0); // bne not taken
		addRow(opcodeBranch, 4, 0, 4, 1, 0, -8, 0, 0); // blt taken backwards
		addRow(opcodeBranch, 5, 0, 4, 1, 0, 12, 0, 0); // bge not taken
		addRow(opcodeBranch, 7, 0, 4, 1, 0, 20, 0, 0); // bgeu taken
		addRow(opcodeJal, 0, 0, 0, 0, 24, 32'h40, 0, 0);
		addRow(opcodeJalr, 0, 0, 1, 0, 25, 32'h20, 0, 0); // odd target
		addRow(opcodeR, 0, 0, 22, 20, 26, 0, 0, 0); // x22 must still be zero
		rngState = xorshift(rngState);
		addRow(opcodeLui, 0, 0, 0, 0, 27, rngState & 32'hffff_f000, 0, 0);
		rngState = xorshift(rngState);
		addRow(opcodeImm, 0, 0, 27, 0, 28, {{20{rngState[11]}}, rngState[11:0]}, 0, 0);
		rngState = xorshift(rngState);
		addRow(opcodeImm, 1, 0, 28, 0, 29, rngState[4:0], 0, 0);
		addRow(opcodeR, 3, 0, 29, 27, 30, 0, 0, 0);
	endtask

	task automatic driveRow(rowT r);
		opcode <= r.opcode;
		func3 <= r.func3;
		func7 <= r.func7;
		regNum0 <= r.rs1;
		regNum1 <= r.rs2;
		regWriteNumIn <= r.rd;
		imm <= r.imm;
		pc <= r.pc;
		flush <= r.flush;
	endtask

	task automatic runTable();
		expectT want;
		for (int i = 0; i <= rows.size(); i++)
		begin
			@(posedge clk);
			if (i < rows.size())
				driveRow(rows[i]);
			else
				flush <= 1'b1; // trailing bubble
			if (i > 0)
				memReadData <= rows[i-1].memData; // data for the load now in writeback
			@(negedge clk);
			if (i > 0)
			begin
				want = predict(rows[i-1]);
				checkRow(i - 1, rows[i-1], want);
				if (want.regWe)
					refRegs[rows[i-1].rd] = want.regData;
			end
		end
	endtask

	initial
	begin
		reset = 1'b1;
		flush = 1'b0;
		pc = '0;
		imm = '0;
		func3 = '0;
		func7 = '0;
		opcode = opcodeJal; // live jump held while reset is high
		regNum0 = '0;
		regNum1 = '0;
		regWriteNumIn = 5'd1;
		memReadData = '0;
		checks = 0;
		errors = 0;
		rngState = 32'd44;
		for (int r = 0; r < numRegs; r++)
			refRegs[r] = '0;
		buildTable();
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		flush <= 1'b1; // bubble until the table starts
		@(negedge clk);
		checks++;
		if (!strobesLow())
		begin
			errors++;
			$display("ERROR time %0t: strobes not all low right after reset", $time);
		end
		runTable();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

//--- project.f
hw/executePkg.sv
hw/aluUnit.sv
hw/opDecoder.sv
hw/forwardUnit.sv
hw/regFile.sv
hw/writebackController.sv
hw/executeStage.sv
verif/executeStageTb.sv
